// ==== bench/regfile_assertions.sv ====
/* bound checker, shadow register model and concurrent assertions
   on both read ports */

`timescale 1ns/1ps

module regfile_assertions
#(
    // write ports of the bound register file
    parameter int NUM_WR_PORTS = 4
)
(
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  regfile_pkg::wr_port_t [NUM_WR_PORTS-1:0] wr_i,
    input  regfile_pkg::reg_addr_t                   ra_i,
    input  regfile_pkg::reg_addr_t                   rb_i,
    // observed read values of the DUT
    input  regfile_pkg::reg_data_t                   ra_value_i,
    input  regfile_pkg::reg_data_t                   rb_value_i
);

    import regfile_pkg::*;

    // x0 included, never written
    localparam int SHADOW_SIZE = 32;

    reg_data_t shadow [SHADOW_SIZE];

    // read by the testbench for the closing line
    int error_count = 0;
    int checked_cycles = 0;

    // expected read values
    reg_data_t exp_a;
    reg_data_t exp_b;

    // --------------------------------------------------
    // shadow model
    // --------------------------------------------------

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < SHADOW_SIZE; i++)
            begin
                shadow[i] <= '0;
            end
        end
        else
        begin
            // port 0 applied last, so it wins a clash
            for (int p = NUM_WR_PORTS - 1; p >= 0; p--)
            begin
                // writes to x0 are dropped
                if (wr_i[p].addr != '0)
                begin
                    shadow[wr_i[p].addr] <= wr_i[p].data;
                end
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        checked_cycles <= checked_cycles + 1;
    end

    assign exp_a = shadow[ra_i];
    assign exp_b = shadow[rb_i];

    // --------------------------------------------------
    // read port checks
    // --------------------------------------------------

    read_a_matches: assert property (@(posedge clk_i) ra_value_i == exp_a)
    else
    begin
        error_count = error_count + 1;
        $error("Mismatch at %0t: ra_value_o expected %h, actual %h",
               $time, $sampled(exp_a), $sampled(ra_value_i));
    end

    read_b_matches: assert property (@(posedge clk_i) rb_value_i == exp_b)
    else
    begin
        error_count = error_count + 1;
        $error("Mismatch at %0t: rb_value_o expected %h, actual %h",
               $time, $sampled(exp_b), $sampled(rb_value_i));
    end

    // everything reads zero while in reset
    reset_reads_zero: assert property (@(posedge clk_i)
        rst_i |-> (ra_value_i == '0 && rb_value_i == '0))
    else
    begin
        error_count = error_count + 1;
        $error("Mismatch at %0t: ra_value_o/rb_value_o in reset expected 0, actual %h/%h",
               $time, $sampled(ra_value_i), $sampled(rb_value_i));
    end

    // x0 is hard wired
    zero_reg_reads_zero: assert property (@(posedge clk_i)
        (ra_i == '0 || rb_i == '0) |->
        ((ra_i != '0 || ra_value_i == '0) && (rb_i != '0 || rb_value_i == '0)))
    else
    begin
        error_count = error_count + 1;
        $error("Mismatch at %0t: x0 read on ra_value_o/rb_value_o expected 0, actual %h/%h",
               $time, $sampled(ra_value_i), $sampled(rb_value_i));
    end

endmodule

// ==== bench/regfile_tb.sv ====
/* testbench for the register file, clock, reset and LFSR stimulus
   with the closing result line */

`timescale 1ns/1ps

module regfile_tb;

    import regfile_pkg::*;

    localparam int NUM_WR_PORTS  = 4;
    localparam int CLK_PERIOD_NS = 40;
    localparam int RESET_CYCLES  = 2;
    localparam int WAIT_LIMIT    = 50;
    localparam int RANDOM_CYCLES = 400;

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_SEED = 32'd44;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef wr_port_t [NUM_WR_PORTS-1:0] wr_bus_t;

    logic      clk_i;
    logic      rst_i;
    wr_bus_t   wr_i;
    reg_addr_t ra_i;
    reg_addr_t rb_i;
    reg_data_t ra_value_o;
    reg_data_t rb_value_o;

    logic [31:0] lfsr_state;
    int          timeout_count;

    regfile_top
    #(
        .NUM_WR_PORTS (NUM_WR_PORTS)
    )
    regfile_top_i
    (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_i       (wr_i),
        .ra_i       (ra_i),
        .rb_i       (rb_i),
        .ra_value_o (ra_value_o),
        .rb_value_o (rb_value_o)
    );

    // checker sits inside the DUT
    bind regfile_top regfile_assertions
    #(
        .NUM_WR_PORTS (NUM_WR_PORTS)
    )
    assertions_i
    (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_i       (wr_i),
        .ra_i       (ra_i),
        .rb_i       (rb_i),
        .ra_value_i (ra_value_o),
        .rb_value_i (rb_value_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out)
            begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    // new inputs right after the rising edge
    task automatic drive(input wr_bus_t bus, input reg_addr_t ra, input reg_addr_t rb);
        @(posedge clk_i);
        wr_i <= bus;
        ra_i <= ra;
        rb_i <= rb;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_i !== 1'b0 && n < WAIT_LIMIT)
        begin
            @(posedge clk_i);
            n++;
        end
        if (rst_i !== 1'b0)
        begin
            timeout_count++;
            $display("timeout: reset still active after %0d cycles", WAIT_LIMIT);
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    initial
    begin
        wr_bus_t   bus;
        reg_addr_t addr;
        rst_i         = 1'b1;
        wr_i          = '0;
        ra_i          = '0;
        rb_i          = '0;
        lfsr_state    = LFSR_SEED;
        timeout_count = 0;

        // reads while in reset
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            drive('0, reg_addr_t'(c + 1), reg_addr_t'(30 - c));
        end
        rst_i <= 1'b0;
        wait_reset_release();

        // every address reads zero before any write
        for (int a = 0; a < REG_COUNT; a++)
        begin
            drive('0, reg_addr_t'(a), reg_addr_t'(REG_COUNT - 1 - a));
        end

        // one port at a time, read back on both ports
        for (int p = 0; p < NUM_WR_PORTS; p++)
        begin
            addr = reg_addr_t'(take_bits(REG_ADDR_W));
            if (addr == '0)
            begin
                addr = reg_addr_t'(1);
            end
            bus = '0;
            bus[p].addr = addr;
            bus[p].data = take_bits(REG_DATA_W);
            drive(bus, addr, addr);
            drive('0, addr, addr);
        end

        // x0 writes on every port
        for (int p = 0; p < NUM_WR_PORTS; p++)
        begin
            bus[p].addr = '0;
            bus[p].data = take_bits(REG_DATA_W);
        end
        drive(bus, '0, '0);
        drive('0, '0, '0);

        // all ports clash on x9
        for (int p = 0; p < NUM_WR_PORTS; p++)
        begin
            bus[p].addr = reg_addr_t'(9);
            bus[p].data = take_bits(REG_DATA_W);
        end
        drive(bus, reg_addr_t'(9), reg_addr_t'(9));
        drive('0, reg_addr_t'(9), reg_addr_t'(9));

        // two upper ports clash on x17
        bus = '0;
        bus[NUM_WR_PORTS - 1].addr = reg_addr_t'(17);
        bus[NUM_WR_PORTS - 1].data = take_bits(REG_DATA_W);
        bus[NUM_WR_PORTS / 2].addr = reg_addr_t'(17);
        bus[NUM_WR_PORTS / 2].data = take_bits(REG_DATA_W);
        drive(bus, reg_addr_t'(17), reg_addr_t'(17));
        drive('0, reg_addr_t'(17), '0);

        // distinct targets, all land in one edge
        for (int p = 0; p < NUM_WR_PORTS; p++)
        begin
            bus[p].addr = reg_addr_t'(p + 4);
            bus[p].data = take_bits(REG_DATA_W);
        end
        drive(bus, '0, '0);
        for (int p = 0; p < NUM_WR_PORTS; p += 2)
        begin
            drive('0, reg_addr_t'(p + 4), reg_addr_t'(p + 5));
        end

        // random traffic, small address range now and then for clashes
        for (int c = 0; c < RANDOM_CYCLES; c++)
        begin
            for (int p = 0; p < NUM_WR_PORTS; p++)
            begin
                if (take_bits(2) == 0)
                begin
                    bus[p].addr = reg_addr_t'(take_bits(2));
                end
                else
                begin
                    bus[p].addr = reg_addr_t'(take_bits(REG_ADDR_W));
                end
                bus[p].data = take_bits(REG_DATA_W);
            end
            drive(bus, reg_addr_t'(take_bits(REG_ADDR_W)), reg_addr_t'(take_bits(REG_ADDR_W)));
        end

        drive('0, '0, '0);
        // checks of the last random cycle have run by mid cycle
        @(negedge clk_i);

        $display("checked %0d cycles: %0d assertion errors, %0d timeouts",
                 regfile_top_i.assertions_i.checked_cycles,
                 regfile_top_i.assertions_i.error_count, timeout_count);
        if (regfile_top_i.assertions_i.error_count == 0 && timeout_count == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
source/regfile_pkg.sv
source/regfile_write_select.sv
source/regfile_array.sv
source/regfile_top.sv
bench/regfile_assertions.sv
bench/regfile_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the register file testbench with Verilator
# the error limit lets every assertion failure be counted

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module regfile_tb -f list.f -o regfile_sim &&
    ./obj_dir/regfile_sim +verilator+error+limit+100000 | tee /dev/stderr |
    grep -q "RESULT: PASS" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

exit 0

// ==== source/regfile_array.sv ====
/* flop storage for x1..x31 with asynchronous reset and the two
   combinational read ports */

`timescale 1ns/1ps

module regfile_array
(
    input  logic                                               clk_i,
    input  logic                                               rst_i,

    // write command per register, bit 0 never set
    input  logic [regfile_pkg::REG_COUNT-1:0]                  wr_en_i,
    input  regfile_pkg::reg_data_t [regfile_pkg::REG_COUNT-1:0] wr_data_i,

    // read port addresses
    input  regfile_pkg::reg_addr_t                             ra_i,
    input  regfile_pkg::reg_addr_t                             rb_i,

    // read port values, same cycle as the address
    output regfile_pkg::reg_data_t                             ra_value_o,
    output regfile_pkg::reg_data_t                             rb_value_o
);

    import regfile_pkg::*;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------

    // x1..x31 only
    // x0 has no flops behind it
    reg_data_t reg_q [1:REG_COUNT-1];

    // architectural state, cleared by reset
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 1; i < REG_COUNT; i++)
            begin
                reg_q[i] <= '0;
            end
        end
        else
        begin
            // several registers may be written in the same edge
            for (int i = 1; i < REG_COUNT; i++)
            begin
                if (wr_en_i[i])
                begin
                    reg_q[i] <= wr_data_i[i];
                end
            end
        end
    end

    // --------------------------------------------------
    // read view
    // --------------------------------------------------

    // full 32-entry view for the read muxes
    reg_data_t [REG_COUNT-1:0] reg_view;

    always_comb
    begin
        // slot 0 reads as constant zero
        reg_view[0] = '0;
        for (int i = 1; i < REG_COUNT; i++)
        begin
            reg_view[i] = reg_q[i];
        end
    end

    // --------------------------------------------------
    // read ports
    // --------------------------------------------------

    // and-or selection of one entry by address
    // one term per register, no priority chain
    function automatic reg_data_t read_sel
    (
        input reg_addr_t                 addr,
        input reg_data_t [REG_COUNT-1:0] regs
    );
        reg_data_t value;
        value = '0;
        for (int i = 0; i < REG_COUNT; i++)
        begin
            if (addr == reg_addr_t'(i))
            begin
                value = value | regs[i];
            end
        end
        return value;
    endfunction

    // port a
    assign ra_value_o = read_sel(ra_i, reg_view);

    // port b, independent of port a
    assign rb_value_o = read_sel(rb_i, reg_view);

endmodule

// ==== source/regfile_pkg.sv ====
/* widths, register count, vector types and the write-port struct
   shared by the integer register file */

package regfile_pkg;

    // --------------------------------------------------
    // widths and sizes
    // --------------------------------------------------

    // register index, selects x0..x31
    localparam int REG_ADDR_W = 5;

    // one register value
    localparam int REG_DATA_W = 32;

    // architectural registers, x0 included
    // every address value names a register
    localparam int REG_COUNT = 2 ** REG_ADDR_W;

    // --------------------------------------------------
    // types
    // --------------------------------------------------

    // names a register
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // holds a register value
    typedef logic [REG_DATA_W-1:0] reg_data_t;

    // one write port, 37 bits
    // no valid bit, an idle port drives addr 0
    typedef struct packed
    {
        reg_addr_t addr;
        reg_data_t data;
    } wr_port_t;

endpackage

// ==== source/regfile_top.sv ====
/* top level of the multi-port integer register file, write
   selection feeding the register array */

`timescale 1ns/1ps

module regfile_top
#(
    // write ports per cycle
    parameter int NUM_WR_PORTS = 4
)
(
    input  logic                                    clk_i,
    input  logic                                    rst_i,

    // write ports, lowest index wins on a clash
    // addr 0 marks an idle port
    input  regfile_pkg::wr_port_t [NUM_WR_PORTS-1:0] wr_i,

    // read addresses
    input  regfile_pkg::reg_addr_t                  ra_i,
    input  regfile_pkg::reg_addr_t                  rb_i,

    // read values
    output regfile_pkg::reg_data_t                  ra_value_o,
    output regfile_pkg::reg_data_t                  rb_value_o
);

    import regfile_pkg::*;

    // --------------------------------------------------
    // write commands, select to array
    // --------------------------------------------------

    // one enable per register
    logic [REG_COUNT-1:0]      wr_en;

    // chosen value per register
    reg_data_t [REG_COUNT-1:0] wr_data;

    // --------------------------------------------------
    // instances
    // --------------------------------------------------

    // combinational, same cycle as wr_i
    regfile_write_select
    #(
        .NUM_WR_PORTS (NUM_WR_PORTS)
    )
    write_select_i
    (
        .wr_i      (wr_i),
        .wr_en_o   (wr_en),
        .wr_data_o (wr_data)
    );

    // captures on the rising edge
    // reads are combinational
    regfile_array array_i
    (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_en_i    (wr_en),
        .wr_data_i  (wr_data),
        .ra_i       (ra_i),
        .rb_i       (rb_i),
        .ra_value_o (ra_value_o),
        .rb_value_o (rb_value_o)
    );

endmodule

// ==== source/regfile_write_select.sv ====
/* priority selection of the write ports into one write enable and
   one write value per register */

`timescale 1ns/1ps

module regfile_write_select
#(
    // number of write ports, 1 or more
    parameter int NUM_WR_PORTS = 4
)
(
    // write ports, index 0 has the highest priority
    input  regfile_pkg::wr_port_t [NUM_WR_PORTS-1:0]          wr_i,

    // per-register write command
    output logic [regfile_pkg::REG_COUNT-1:0]                 wr_en_o,
    output regfile_pkg::reg_data_t [regfile_pkg::REG_COUNT-1:0] wr_data_o
);

    import regfile_pkg::*;

    // --------------------------------------------------
    // destination decode
    // --------------------------------------------------

    // one-hot destination of each port
    // bit 0 is always clear
    logic [NUM_WR_PORTS-1:0][REG_COUNT-1:0] port_hit;

    always_comb
    begin
        for (int p = 0; p < NUM_WR_PORTS; p++)
        begin
            port_hit[p] = '0;
            port_hit[p][wr_i[p].addr] = 1'b1;

            // x0 is hard wired to zero
            // a write to it, or an idle port, hits nothing
            port_hit[p][0] = 1'b0;
        end
    end

    // --------------------------------------------------
    // per-register priority
    // --------------------------------------------------

    // x0 never gets a command
    assign wr_en_o[0]   = 1'b0;
    assign wr_data_o[0] = '0;

    for (genvar r = 1; r < REG_COUNT; r++)
    begin : g_reg

        // any port aimed at this register
        logic      hit_any;

        // value of the winning port
        reg_data_t sel_data;

        always_comb
        begin
            hit_any  = 1'b0;
            sel_data = '0;

            // scan from the top port down
            // the lowest matching port is seen last and wins
            for (int p = NUM_WR_PORTS - 1; p >= 0; p--)
            begin
                if (port_hit[p][r])
                begin
                    hit_any  = 1'b1;
                    sel_data = wr_i[p].data;
                end
            end
        end

        assign wr_en_o[r]   = hit_any;
        // zero when nobody writes, the array ignores it then
        assign wr_data_o[r] = sel_data;

    end

endmodule
